// ==== source/hazardPkg.sv ====
package hazardPkg;

    //////////////////////////////////////////////////////////////////////
    // Primary opcodes
    //////////////////////////////////////////////////////////////////////
    localparam logic [5:0] opR      = 6'h00;
    localparam logic [5:0] opJ      = 6'h02;
    localparam logic [5:0] opJal    = 6'h03;
    localparam logic [5:0] opBeq    = 6'h04;
    localparam logic [5:0] opBne    = 6'h05;
    localparam logic [5:0] opAddi   = 6'h08;
    localparam logic [5:0] opAndi   = 6'h0c;
    localparam logic [5:0] opOri    = 6'h0d;
    localparam logic [5:0] opLui    = 6'h0f;
    localparam logic [5:0] opLb     = 6'h20;
    localparam logic [5:0] opLh     = 6'h21;
    localparam logic [5:0] opLw     = 6'h23;
    localparam logic [5:0] opSb     = 6'h28;
    localparam logic [5:0] opSh     = 6'h29;
    localparam logic [5:0] opSw     = 6'h2b;
    // Conditional load on the reserved slot
    localparam logic [5:0] opLhonez = 6'h3b;

    //////////////////////////////////////////////////////////////////////
    // Function codes under opR
    //////////////////////////////////////////////////////////////////////
    localparam logic [5:0] fnJr    = 6'h08;
    localparam logic [5:0] fnMfhi  = 6'h10;
    localparam logic [5:0] fnMthi  = 6'h11;
    localparam logic [5:0] fnMflo  = 6'h12;
    localparam logic [5:0] fnMtlo  = 6'h13;
    localparam logic [5:0] fnMult  = 6'h18;
    localparam logic [5:0] fnMultu = 6'h19;
    localparam logic [5:0] fnDiv   = 6'h1a;
    localparam logic [5:0] fnDivu  = 6'h1b;
    localparam logic [5:0] fnAdd   = 6'h20;
    localparam logic [5:0] fnSub   = 6'h22;
    localparam logic [5:0] fnAnd   = 6'h24;
    localparam logic [5:0] fnOr    = 6'h25;
    localparam logic [5:0] fnSlt   = 6'h2a;
    localparam logic [5:0] fnSltu  = 6'h2b;

    // Register 0 doubles as "no register"
    typedef logic [4:0] regIdx;
    // Tuse and Tnew share this width
    typedef logic [1:0] stageTime;

    localparam regIdx regRa = 5'd31;

    // Same 32 bits, R-type or I-type field split
    typedef union packed {
        struct packed {
            logic [5:0] op;
            regIdx      rs;
            regIdx      rt;
            regIdx      rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } rView;
        struct packed {
            logic [5:0]  op;
            regIdx       rs;
            regIdx       rt;
            logic [15:0] imm;
        } iView;
    } instrWord;

endpackage

// ==== source/useDecoder.sv ====
`timescale 1ns/1ps

module useDecoder import hazardPkg::*; (
    input  instrWord instrD,
    output regIdx    rsUse,
    output regIdx    rtUse,
    output stageTime tuseRs,
    output stageTime tuseRt,
    output logic     mdMove,
    output logic     mdStart
);

    always_comb begin
        rsUse   = '0;
        rtUse   = '0;
        tuseRs  = '0;
        tuseRt  = '0;
        mdMove  = 1'b0;
        mdStart = 1'b0;

        case (instrD.iView.op)
            opR: begin
                case (instrD.rView.funct)
                    fnAdd, fnSub, fnAnd, fnOr, fnSlt, fnSltu: begin
                        rsUse  = instrD.rView.rs;
                        rtUse  = instrD.rView.rt;
                        tuseRs = 2'd1;
                        tuseRt = 2'd1;
                    end
                    fnMult, fnMultu, fnDiv, fnDivu: begin
                        rsUse   = instrD.rView.rs;
                        rtUse   = instrD.rView.rt;
                        tuseRs  = 2'd1;
                        tuseRt  = 2'd1;
                        mdStart = 1'b1;
                    end
                    // Reads hi/lo, no GPR source
                    fnMfhi, fnMflo: begin
                        mdMove = 1'b1;
                    end
                    fnMthi, fnMtlo: begin
                        rsUse  = instrD.rView.rs;
                        tuseRs = 2'd1;
                        mdMove = 1'b1;
                    end
                    // Jump target needed in decode
                    fnJr: begin
                        rsUse  = instrD.rView.rs;
                        tuseRs = 2'd0;
                    end
                    default: begin
                    end
                endcase
            end

            opOri, opAddi, opAndi, opLw, opLb, opLh, opLhonez: begin
                rsUse  = instrD.iView.rs;
                tuseRs = 2'd1;
            end

            // Store data is not needed until memory
            opSw, opSb, opSh: begin
                rsUse  = instrD.iView.rs;
                rtUse  = instrD.iView.rt;
                tuseRs = 2'd1;
                tuseRt = 2'd2;
            end

            // Branches compare in decode
            opBeq, opBne: begin
                rsUse  = instrD.iView.rs;
                rtUse  = instrD.iView.rt;
                tuseRs = 2'd0;
                tuseRt = 2'd0;
            end

            default: begin
            end
        endcase
    end

endmodule

// ==== source/writeDecoder.sv ====
`timescale 1ns/1ps

module writeDecoder import hazardPkg::*; (
    input  instrWord instrE,
    output regIdx    destE,
    output stageTime tnewE,
    output logic     isLhonezE
);

    always_comb begin
        destE     = '0;
        tnewE     = '0;
        isLhonezE = 1'b0;

        case (instrE.iView.op)
            opR: begin
                case (instrE.rView.funct)
                    fnAdd, fnSub, fnAnd, fnOr, fnSlt, fnSltu,
                    fnMfhi, fnMflo: begin
                        destE = instrE.rView.rd;
                        tnewE = 2'd1;
                    end
                    // mult/div, mt*, jr write no GPR
                    default: begin
                    end
                endcase
            end

            // ALU result ready at end of execute
            opOri, opAddi, opAndi, opLui: begin
                destE = instrE.iView.rt;
                tnewE = 2'd1;
            end

            opLw, opLb, opLh: begin
                destE = instrE.iView.rt;
                tnewE = 2'd2;
            end

            opLhonez: begin
                destE     = instrE.iView.rt;
                tnewE     = 2'd2;
                isLhonezE = 1'b1;
            end

            // Link address is already known
            opJal: begin
                destE = regRa;
                tnewE = 2'd0;
            end

            default: begin
            end
        endcase
    end

endmodule

// ==== source/tnewTracker.sv ====
`timescale 1ns/1ps

module tnewTracker import hazardPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  regIdx    destE,
    input  stageTime tnewE,
    input  logic     regWriteE,
    input  logic     isLhonezE,
    input  logic     condition,
    output regIdx    destM,
    output stageTime tnewM,
    output logic     writeM
);

    logic writeRegM;
    logic lhonezM;

    //////////////////////////////////////////////////////////////////////
    // Producer moving from execute into memory
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            destM     <= '0;
            tnewM     <= '0;
            writeRegM <= 1'b0;
            lhonezM   <= 1'b0;
        end else begin
            destM     <= destE;
            // One stage closer, never below zero
            tnewM     <= (tnewE == 2'd0) ? 2'd0 : tnewE - 2'd1;
            writeRegM <= regWriteE;
            lhonezM   <= isLhonezE;
        end
    end

    // Failed lhonez condition drops the write
    assign writeM = writeRegM & ~(lhonezM & ~condition);

endmodule

// ==== source/stallControl.sv ====
`timescale 1ns/1ps

module stallControl import hazardPkg::*; (
    input  regIdx    rsUse,
    input  regIdx    rtUse,
    input  regIdx    destE,
    input  regIdx    destM,
    input  stageTime tuseRs,
    input  stageTime tuseRt,
    input  stageTime tnewE,
    input  stageTime tnewM,
    input  logic     regWriteE,
    input  logic     writeM,
    input  logic     isLhonezE,
    input  logic     mdMove,
    input  logic     mdStart,
    input  logic     busy,
    input  logic     start,
    output logic     pcWrite,
    output logic     ifIdEn,
    output logic     idExClr,
    output logic     mduClr
);

    logic rsHitE;
    logic rsHitM;
    logic rtHitE;
    logic rtHitM;
    logic mduActive;
    logic stall;

    // Reader needs the value before the producer has it
    function automatic logic lateHit(regIdx src, stageTime tuse, regIdx dest,
                                     logic wr, stageTime tnew);
        return (src != 5'd0) && (src == dest) && wr && (tuse < tnew);
    endfunction

    assign rsHitE = lateHit(rsUse, tuseRs, destE, regWriteE, tnewE);
    assign rsHitM = lateHit(rsUse, tuseRs, destM, writeM, tnewM);
    assign rtHitE = lateHit(rtUse, tuseRt, destE, regWriteE, tnewE);
    assign rtHitM = lateHit(rtUse, tuseRt, destM, writeM, tnewM);

    assign mduActive = busy | start;

    //////////////////////////////////////////////////////////////////////
    // Pipeline controls
    //////////////////////////////////////////////////////////////////////
    assign stall = rsHitE | rsHitM | rtHitE | rtHitM
                 | (mdMove & mduActive)
                 | isLhonezE;

    assign pcWrite = ~stall;
    assign ifIdEn  = ~stall;
    assign idExClr = stall;

    // New mult/div restarts a busy unit
    assign mduClr = mdStart & mduActive;

endmodule

// ==== source/hazardUnit.sv ====
`timescale 1ns/1ps

module hazardUnit import hazardPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  instrWord instrD,
    input  instrWord instrE,
    input  logic     regWriteE,
    input  logic     condition,
    input  logic     busy,
    input  logic     start,
    output logic     pcWrite,
    output logic     ifIdEn,
    output logic     idExClr,
    output logic     mduClr,
    output regIdx    rsUseD,
    output regIdx    rtUseD,
    output stageTime tnewE,
    output stageTime tnewM
);

    stageTime tuseRs;
    stageTime tuseRt;
    logic     mdMove;
    logic     mdStart;
    regIdx    destE;
    regIdx    destM;
    logic     isLhonezE;
    logic     writeM;

    //////////////////////////////////////////////////////////////////////
    // Decode-stage readers, execute-stage producer
    //////////////////////////////////////////////////////////////////////
    useDecoder uUse (
        .instrD  (instrD),
        .rsUse   (rsUseD),
        .rtUse   (rtUseD),
        .tuseRs  (tuseRs),
        .tuseRt  (tuseRt),
        .mdMove  (mdMove),
        .mdStart (mdStart)
    );

    writeDecoder uWrite (
        .instrE    (instrE),
        .destE     (destE),
        .tnewE     (tnewE),
        .isLhonezE (isLhonezE)
    );

    tnewTracker uTrack (
        .clk       (clk),
        .rstN      (rstN),
        .destE     (destE),
        .tnewE     (tnewE),
        .regWriteE (regWriteE),
        .isLhonezE (isLhonezE),
        .condition (condition),
        .destM     (destM),
        .tnewM     (tnewM),
        .writeM    (writeM)
    );

    stallControl uStall (
        .rsUse     (rsUseD),
        .rtUse     (rtUseD),
        .destE     (destE),
        .destM     (destM),
        .tuseRs    (tuseRs),
        .tuseRt    (tuseRt),
        .tnewE     (tnewE),
        .tnewM     (tnewM),
        .regWriteE (regWriteE),
        .writeM    (writeM),
        .isLhonezE (isLhonezE),
        .mdMove    (mdMove),
        .mdStart   (mdStart),
        .busy      (busy),
        .start     (start),
        .pcWrite   (pcWrite),
        .ifIdEn    (ifIdEn),
        .idExClr   (idExClr),
        .mduClr    (mduClr)
    );

endmodule

// ==== dv/hazardUnit_chk.sv ====
`timescale 1ns/1ps

module hazardUnit_chk import hazardPkg::*; (
    input logic     clk,
    input logic     rstN,
    input instrWord instrE,
    input logic     busy,
    input logic     start,
    input logic     pcWrite,
    input logic     ifIdEn,
    input logic     idExClr,
    input regIdx    rsUseD,
    input regIdx    rtUseD,
    input stageTime tnewM
);

    int failCount = 0;

    enableMatch: assert property (@(posedge clk) disable iff (!rstN) pcWrite == ifIdEn)
        else begin
            $error("pcWrite and ifIdEn disagree");
            failCount++;
        end

    clrInverse: assert property (@(posedge clk) disable iff (!rstN) idExClr == !pcWrite)
        else begin
            $error("idExClr is not the inverse of pcWrite");
            failCount++;
        end

    tnewMAfterReset: assert property (@(posedge clk) $rose(rstN) |-> tnewM == 2'd0)
        else begin
            $error("tnewM not zero right after reset release");
            failCount++;
        end

    // Nothing to wait for, so decode must flow
    noFalseStall: assert property (@(posedge clk) disable iff (!rstN)
        (rsUseD == '0 && rtUseD == '0 && instrE.iView.op != opLhonez && !busy && !start)
        |-> pcWrite)
        else begin
            $error("stall raised with no source register and no lhonez");
            failCount++;
        end

endmodule

bind hazardUnit hazardUnit_chk uChk (.clk(clk), .rstN(rstN), .instrE(instrE), .busy(busy),
    .start(start), .pcWrite(pcWrite), .ifIdEn(ifIdEn), .idExClr(idExClr),
    .rsUseD(rsUseD), .rtUseD(rtUseD), .tnewM(tnewM));

// ==== dv/tbHazardUnit.sv ====
`timescale 1ns/1ps

module tbHazardUnit import hazardPkg::*; ();

    logic     clk = 1'b0;
    logic     rstN;
    instrWord instrD, instrE;
    logic     regWriteE, condition, busy, start;
    logic     pcWrite, ifIdEn, idExClr, mduClr;
    regIdx    rsUseD, rtUseD, eDest, mDest;
    stageTime tnewE, tnewM, eTnew, mTnew;
    logic     eLh, mLh, mWrite;
    int       cycles = 0;

    hazardUnit UUT (.clk(clk), .rstN(rstN), .instrD(instrD), .instrE(instrE),
        .regWriteE(regWriteE), .condition(condition), .busy(busy), .start(start),
        .pcWrite(pcWrite), .ifIdEn(ifIdEn), .idExClr(idExClr), .mduClr(mduClr),
        .rsUseD(rsUseD), .rtUseD(rtUseD), .tnewE(tnewE), .tnewM(tnewM));

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 400) begin
            $display("TB FAILED");
            $fatal(1, "Timeout after %0d cycles", cycles);
        end
    end

    // Bound checker failures end the run
    always @(UUT.uChk.failCount) begin
        if (UUT.uChk.failCount != 0) begin
            $display("TB FAILED");
            $fatal(1, "Assertion in hazardUnit_chk failed");
        end
    end

    function automatic instrWord rType(logic [5:0] fn, regIdx rs, regIdx rt, regIdx rd);
        instrWord w;
        w = '0;
        w.rView.funct = fn;
        w.rView.rs = rs;
        w.rView.rt = rt;
        w.rView.rd = rd;
        return w;
    endfunction

    function automatic instrWord iType(logic [5:0] op, regIdx rs, regIdx rt);
        instrWord w;
        w = '0;
        w.iView.op = op;
        w.iView.rs = rs;
        w.iView.rt = rt;
        return w;
    endfunction

    function automatic regIdx randReg();
        return regIdx'($urandom % 30 + 1);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////
    function automatic void refUse(input instrWord w, output regIdx rs, output regIdx rt,
            output stageTime trs, output stageTime trt, output logic mv, output logic sd);
        logic isR;
        logic aluFn;
        isR = (w.iView.op == opR);
        aluFn = isR && (w.rView.funct inside {fnAdd, fnSub, fnAnd, fnOr, fnSlt, fnSltu});
        mv = isR && (w.rView.funct inside {fnMfhi, fnMflo, fnMthi, fnMtlo});
        sd = isR && (w.rView.funct inside {fnMult, fnMultu, fnDiv, fnDivu});
        rs = '0;
        rt = '0;
        trs = 2'd1;
        trt = 2'd1;
        if (aluFn || sd || (isR && w.rView.funct inside {fnMthi, fnMtlo, fnJr}))
            rs = w.rView.rs;
        if (aluFn || sd)
            rt = w.rView.rt;
        if (w.iView.op inside {opOri, opAddi, opAndi, opLw, opLb, opLh, opLhonez})
            rs = w.iView.rs;
        if (w.iView.op inside {opSw, opSb, opSh, opBeq, opBne}) begin
            rs = w.iView.rs;
            rt = w.iView.rt;
        end
        if (w.iView.op inside {opSw, opSb, opSh})
            trt = 2'd2;
        // Compare in decode
        if (w.iView.op inside {opBeq, opBne} || (isR && w.rView.funct == fnJr)) begin
            trs = 2'd0;
            trt = 2'd0;
        end
    endfunction

    function automatic void refWrite(input instrWord w, output regIdx dest,
            output stageTime tnew, output logic lh);
        dest = '0;
        tnew = 2'd0;
        lh = (w.iView.op == opLhonez);
        if (w.iView.op == opR && (w.rView.funct inside
                {fnAdd, fnSub, fnAnd, fnOr, fnSlt, fnSltu, fnMfhi, fnMflo})) begin
            dest = w.rView.rd;
            tnew = 2'd1;
        end
        if (w.iView.op inside {opOri, opAddi, opAndi, opLui}) begin
            dest = w.iView.rt;
            tnew = 2'd1;
        end
        if (w.iView.op inside {opLw, opLb, opLh, opLhonez}) begin
            dest = w.iView.rt;
            tnew = 2'd2;
        end
        if (w.iView.op == opJal)
            dest = regRa;
    endfunction

    function automatic logic needsStall(regIdx src, stageTime tuse, regIdx dest, logic wr,
            stageTime tnew);
        return (src != 0) && (src == dest) && wr && (tuse < tnew);
    endfunction

    always_comb begin
        refWrite(instrE, eDest, eTnew, eLh);
    end

    // Model copy of the producer one stage ahead
    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mDest <= '0;
            mTnew <= '0;
            mWrite <= 1'b0;
            mLh <= 1'b0;
        end else begin
            mDest <= eDest;
            mTnew <= (eTnew == 0) ? 2'd0 : eTnew - 2'd1;
            mWrite <= regWriteE;
            mLh <= eLh;
        end
    end

    task automatic checkVal(string testName, string what, int expVal, int actVal);
        assert (expVal == actVal) else begin
            $display("Mismatch in %s: %s expected %0d, actual %0d", testName, what, expVal,
                actVal);
            $display("TB FAILED");
            $fatal(1, "Check failed in %s", testName);
        end
    endtask

    task automatic step(string name, instrWord dIn, instrWord eIn, logic we, logic cond,
            logic bsy, logic st, logic expStall, logic expMdu);
        regIdx rsX, rtX;
        stageTime trsX, trtX;
        logic mvX, sdX, wrM, stallX;
        @(posedge clk);
        #1;
        instrD = dIn;
        instrE = eIn;
        regWriteE = we;
        condition = cond;
        busy = bsy;
        start = st;
        @(negedge clk);
        refUse(instrD, rsX, rtX, trsX, trtX, mvX, sdX);
        wrM = mWrite & ~(mLh & ~cond);
        stallX = needsStall(rsX, trsX, eDest, we, eTnew) | needsStall(rtX, trtX, eDest, we, eTnew)
               | needsStall(rsX, trsX, mDest, wrM, mTnew)
               | needsStall(rtX, trtX, mDest, wrM, mTnew)
               | (mvX & (bsy | st)) | eLh;
        checkVal(name, "expected stall", expStall, stallX);
        checkVal(name, "expected mduClr", expMdu, sdX & (bsy | st));
        checkVal(name, "pcWrite", !stallX, pcWrite);
        checkVal(name, "ifIdEn", !stallX, ifIdEn);
        checkVal(name, "idExClr", stallX, idExClr);
        checkVal(name, "mduClr", sdX & (bsy | st), mduClr);
        checkVal(name, "rsUseD", rsX, rsUseD);
        checkVal(name, "rtUseD", rtX, rtUseD);
        checkVal(name, "tnewE", eTnew, tnewE);
        checkVal(name, "tnewM", mTnew, tnewM);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////
    task automatic testPipeline(regIdx r, regIdx r2);
        step("reset", '0, '0, 0, 0, 0, 0, 0, 0);
        step("loadUseAdd", rType(fnAdd, r, r2, r2), iType(opLw, r2, r), 1, 0, 0, 0, 1, 0);
        step("loadUseBeq", iType(opBeq, r2, r), iType(opLw, 0, r), 1, 0, 0, 0, 1, 0);
        step("loadUseSw", iType(opSw, r, r2), iType(opLw, 0, r), 1, 0, 0, 0, 1, 0);
        step("aluStoreData", iType(opSw, r2, r), iType(opAddi, 0, r), 1, 0, 0, 0, 0, 0);
        step("flush", '0, '0, 0, 0, 0, 0, 0, 0);
        step("ageLoad", '0, iType(opLw, 0, r), 1, 0, 0, 0, 0, 0);
        step("ageBeq", iType(opBeq, r, 0), '0, 0, 0, 0, 0, 1, 0);
        step("ageLoad2", '0, iType(opLw, 0, r), 1, 0, 0, 0, 0, 0);
        step("ageAdd", rType(fnAdd, r, 0, r2), '0, 0, 0, 0, 0, 0, 0);
        step("ageAlu", '0, rType(fnAdd, r2, r2, r), 1, 0, 0, 0, 0, 0);
        step("ageAluBeq", iType(opBeq, r, r), '0, 0, 0, 0, 0, 0, 0);
        step("zeroReg", rType(fnAdd, 0, 0, r), iType(opLw, 0, 0), 1, 0, 0, 0, 0, 0);
        step("noWrite", iType(opBeq, r, r2), iType(opLw, 0, r), 0, 0, 0, 0, 0, 0);
        step("noWriteMem", iType(opBeq, r, r2), '0, 0, 0, 0, 0, 0, 0);
    endtask

    task automatic testMduLhonez(regIdx r, regIdx r2);
        step("mfhiBusy", rType(fnMfhi, 0, 0, r), '0, 0, 0, 1, 0, 1, 0);
        step("mthiStart", rType(fnMthi, r, 0, 0), '0, 0, 0, 0, 1, 1, 0);
        step("mfhiIdle", rType(fnMfhi, 0, 0, r), '0, 0, 0, 0, 0, 0, 0);
        step("multBusy", rType(fnMult, r, r2, 0), '0, 0, 0, 1, 0, 0, 1);
        step("divStart", rType(fnDiv, r, r2, 0), '0, 0, 0, 0, 1, 0, 1);
        step("lhonezExec", iType(opBeq, r, 0), iType(opLhonez, 0, r), 1, 0, 0, 0, 1, 0);
        step("lhonezCondLow", iType(opBeq, r, 0), '0, 0, 0, 0, 0, 0, 0);
        step("lhonezExec2", '0, iType(opLhonez, 0, r), 1, 1, 0, 0, 1, 0);
        step("lhonezCondHigh", iType(opBeq, r, 0), '0, 0, 1, 0, 0, 1, 0);
    endtask

    initial begin
        regIdx r, r2;
        void'($urandom(32'h4aa58f77));
        rstN = 1'b0;
        instrD = '0;
        instrE = '0;
        regWriteE = 1'b0;
        condition = 1'b0;
        busy = 1'b0;
        start = 1'b0;
        repeat (3) @(posedge clk);
        #1 rstN = 1'b1;
        r = randReg();
        r2 = regIdx'(r % 30 + 1);
        testPipeline(r, r2);
        testMduLhonez(r, r2);
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== flist.f ====
source/hazardPkg.sv
source/useDecoder.sv
source/writeDecoder.sv
source/tnewTracker.sv
source/stallControl.sv
source/hazardUnit.sv
dv/hazardUnit_chk.sv
dv/tbHazardUnit.sv
